// File: compile.f
verilog/eth_frame_pkg.sv
verilog/host_cmd_pkg.sv
verilog/pkt_ring.sv
verilog/gmii_tx_framer.sv
verilog/gmii_rx_deframer.sv
verilog/host_cmd_decoder.sv
verilog/eth_mac_top.sv
sim/eth_mac_assert.sv
sim/tb_eth_mac.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eth_mac -Mdir obj_dir -o sim_eth_mac -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_eth_mac)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "pass message not found"
exit 1

// File: sim/eth_mac_assert.sv
`timescale 1ns/100ps
`default_nettype none

module eth_mac_assert (
    input logic                    clock,
    input logic                    reset,
    input logic                    host_req,
    input logic                    host_ack,
    input eth_frame_pkg::gmii_tx_t gmii_tx
);

    logic tx_en;

    assign tx_en = gmii_tx.en;

    ack_not_early: assert property (@(posedge clock) disable iff (reset)
        $rose(host_req) |-> !host_ack [*2])
        else $error("host_ack rose less than two cycles after host_req");

    ack_falls_after_req: assert property (@(posedge clock) disable iff (reset)
        $fell(host_ack) |-> !host_req)
        else $error("host_ack fell while host_req was still high");

    tx_gap_kept: assert property (@(posedge clock) disable iff (reset)
        $fell(tx_en) |-> !tx_en [*eth_frame_pkg::IFG_CYCLES])
        else $error("gmii_tx.en rose again inside the inter-frame gap");

endmodule

bind eth_mac_top eth_mac_assert host_gmii_checks (
    .clock    (clock),
    .reset    (reset),
    .host_req (host_req),
    .host_ack (host_ack),
    .gmii_tx  (gmii_tx)
);

`default_nettype wire

// File: sim/tb_eth_mac.sv
`timescale 1ns/100ps
`default_nettype none

module tb_eth_mac;

    typedef logic [7:0] byte_q_t[$];

    localparam int TIMEOUT = 5000;
    localparam int GOOD = 0;
    localparam int BAD_FCS = 1;
    localparam int RX_ERR = 2;
    localparam int BAD_PRE = 3;

    logic clock;
    logic reset;
    logic host_req;
    host_cmd_pkg::host_cmd_t host_cmd;
    logic host_ack;
    host_cmd_pkg::host_rsp_t host_rsp;
    eth_frame_pkg::gmii_tx_t gmii_tx;
    eth_frame_pkg::gmii_rx_t gmii_rx;

    int gap_max = 0;      // idle cycles before a host request
    bit rx_done;
    logic [7:0] tx_byte_q[$];  // expected wire bytes, frames back to back
    int tx_len_q[$];
    logic [7:0] rx_byte_q[$];  // expected payload bytes
    int rx_len_q[$];
    logic [7:0] cap[$];

    eth_mac_top dut (
        .clock    (clock),
        .reset    (reset),
        .host_req (host_req),
        .host_cmd (host_cmd),
        .host_ack (host_ack),
        .host_rsp (host_rsp),
        .gmii_tx  (gmii_tx),
        .gmii_rx  (gmii_rx)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("Error: %s actual 0x%08h expected 0x%08h",
                               name, actual, expected));
        end
    endtask

    function automatic logic [31:0] fcs_of(input byte_q_t p);
        logic [31:0] crc;
        crc = eth_frame_pkg::CRC_INIT;
        foreach (p[i]) begin
            crc = eth_frame_pkg::crc32_byte(p[i], crc);
        end
        return ~crc;
    endfunction

    function automatic byte_q_t rand_payload(input int len);
        byte_q_t p;
        for (int i = 0; i < len; i++) begin
            p.push_back(8'($urandom));
        end
        return p;
    endfunction

    // capture each gmii_tx burst and compare with the next expected frame
    always @(posedge clock) begin
        if (reset) begin
            cap.delete();
        end else if (gmii_tx.en) begin
            cap.push_back(gmii_tx.data);
        end else if (cap.size() != 0) begin
            if (tx_len_q.size() == 0) begin
                fail_run("frame on gmii_tx that was never committed");
            end
            check("gmii_tx frame length", 32'(cap.size()), 32'(tx_len_q.pop_front()));
            foreach (cap[i]) begin
                check("gmii_tx.data", 32'(cap[i]), 32'(tx_byte_q.pop_front()));
            end
            cap.delete();
        end
    end

    task automatic host_xfer(input host_cmd_pkg::host_op_t op, input int addr,
                             input logic [7:0] value, output host_cmd_pkg::host_rsp_t rsp);
        int n;
        repeat ($urandom_range(gap_max, 0)) @(posedge clock);
        @(posedge clock);
        host_cmd <= '{op: op, addr: 7'(addr), value: value};
        host_req <= 1'b1;
        n = 0;
        do begin
            @(posedge clock);
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout waiting for host_ack to rise");
            end
        end while (!host_ack);
        rsp = host_rsp;
        host_req <= 1'b0;
        n = 0;
        do begin
            @(posedge clock);
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout waiting for host_ack to fall");
            end
        end while (host_ack);
    endtask

    task automatic push_tx_model(input byte_q_t p);
        logic [31:0] fcs;
        fcs = fcs_of(p);
        repeat (eth_frame_pkg::PREAMBLE_LEN) tx_byte_q.push_back(eth_frame_pkg::PREAMBLE_BYTE);
        tx_byte_q.push_back(eth_frame_pkg::SFD_BYTE);
        foreach (p[i]) begin
            tx_byte_q.push_back(p[i]);
        end
        for (int i = 0; i < eth_frame_pkg::FCS_BYTES; i++) begin
            tx_byte_q.push_back(fcs[8*i +: 8]);  // low byte first
        end
        tx_len_q.push_back(eth_frame_pkg::PREAMBLE_LEN + 1 + p.size() + eth_frame_pkg::FCS_BYTES);
    endtask

    task automatic push_rx_model(input byte_q_t p);
        foreach (p[i]) begin
            rx_byte_q.push_back(p[i]);
        end
        rx_len_q.push_back(p.size());
    endtask

    // keeps one tx slot open for writing
    task automatic wait_tx_room();
        int n;
        n = 0;
        while (tx_len_q.size() >= eth_frame_pkg::RING_SLOTS) begin
            @(posedge clock);
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout waiting for the transmit ring to drain a slot");
            end
        end
    endtask

    task automatic wait_tx_drained();
        int n;
        n = 0;
        while (tx_len_q.size() != 0) begin
            @(posedge clock);
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout waiting for committed frames on gmii_tx");
            end
        end
        repeat (eth_frame_pkg::IFG_CYCLES + 4) @(posedge clock);
    endtask

    task automatic write_tx_frame(input byte_q_t p);
        host_cmd_pkg::host_rsp_t rsp;
        wait_tx_room();
        foreach (p[i]) begin
            host_xfer(host_cmd_pkg::OP_WRITE, i, p[i], rsp);
            check("host_rsp.flag", 32'(rsp.flag), 0);
            host_xfer(host_cmd_pkg::OP_WRITE_LEN, 0, 8'h00, rsp);
            check("write length", 32'(rsp.data), i + 1);
        end
        host_xfer(host_cmd_pkg::OP_WRITE_NEXT, 0, 8'h00, rsp);
        check("host_rsp.flag", 32'(rsp.flag), 0);
        push_tx_model(p);
    endtask

    task automatic send_rx_frame(input byte_q_t p, input int mode);
        byte_q_t w;
        logic [31:0] fcs;
        int er_pos;
        fcs = fcs_of(p);
        if (mode == BAD_FCS) begin
            fcs = fcs ^ 32'h0000_0100;
        end
        repeat (eth_frame_pkg::PREAMBLE_LEN) w.push_back(eth_frame_pkg::PREAMBLE_BYTE);
        w.push_back(eth_frame_pkg::SFD_BYTE);
        foreach (p[i]) begin
            w.push_back(p[i]);
        end
        for (int i = 0; i < eth_frame_pkg::FCS_BYTES; i++) begin
            w.push_back(fcs[8*i +: 8]);
        end
        if (mode == BAD_PRE) begin
            w[$urandom_range(eth_frame_pkg::PREAMBLE_LEN - 1, 0)] ^= 8'h10;
        end
        er_pos = 8 + p.size() / 2;  // somewhere in the payload
        foreach (w[i]) begin
            @(posedge clock);
            gmii_rx <= '{data: w[i], dv: 1'b1, er: (mode == RX_ERR && i == er_pos)};
        end
        @(posedge clock);
        gmii_rx <= '0;
        repeat (eth_frame_pkg::IFG_CYCLES) @(posedge clock);
    endtask

    task automatic read_rx_frame();
        host_cmd_pkg::host_rsp_t rsp;
        int len;
        if (rx_len_q.size() == 0) begin
            fail_run("receive ring holds a frame that was never sent");
        end
        len = rx_len_q[0];  // frame counts as stored until its slot is released
        host_xfer(host_cmd_pkg::OP_READ_LEN, 0, 8'h00, rsp);
        check("read length", 32'(rsp.data), len);
        for (int i = 0; i < len; i++) begin
            host_xfer(host_cmd_pkg::OP_READ, i, 8'h00, rsp);
            check("read byte", 32'(rsp.data), 32'(rx_byte_q[i]));
        end
        host_xfer(host_cmd_pkg::OP_READ, len, 8'h00, rsp);
        check("read byte past length", 32'(rsp.data), 0);
        host_xfer(host_cmd_pkg::OP_READ, $urandom_range(127, len), 8'h00, rsp);
        check("read byte past length", 32'(rsp.data), 0);
        host_xfer(host_cmd_pkg::OP_READ_NEXT, 0, 8'h00, rsp);
        check("read next flag", 32'(rsp.flag), 0);
        rx_len_q.delete(0);
        repeat (len) rx_byte_q.delete(0);
    endtask

    task automatic check_rx_empty();
        host_cmd_pkg::host_rsp_t rsp;
        host_xfer(host_cmd_pkg::OP_READ_LEN, 0, 8'h00, rsp);
        check("read length on empty ring", 32'(rsp.data), 0);
        host_xfer(host_cmd_pkg::OP_READ_NEXT, 0, 8'h00, rsp);
        check("read next flag on empty ring", 32'(rsp.flag), 1);
    endtask

    task automatic drain_rx();
        host_cmd_pkg::host_rsp_t rsp;
        host_xfer(host_cmd_pkg::OP_READ_LEN, 0, 8'h00, rsp);
        if (rsp.data != 0) begin
            read_rx_frame();
        end
    endtask

    task automatic wait_rx_room();
        int n;
        n = 0;
        while (rx_len_q.size() >= eth_frame_pkg::RING_SLOTS) begin
            @(posedge clock);
            n++;
            if (n > TIMEOUT) begin
                fail_run("timeout waiting for the host to read the receive ring");
            end
        end
    endtask

    initial begin
        byte_q_t p;
        byte_q_t rx_p;
        host_cmd_pkg::host_rsp_t rsp;
        int n;
        void'($urandom(32'hbf38));
        host_req = 1'b0;
        host_cmd = '0;
        gmii_rx = '0;
        reset = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        // random transmit frames
        repeat (6) write_tx_frame(rand_payload($urandom_range(64, 1)));
        wait_tx_drained();

        // out-of-range write, then fill the ring behind one long frame
        p = rand_payload(64);
        foreach (p[i]) begin
            host_xfer(host_cmd_pkg::OP_WRITE, i, p[i], rsp);
        end
        host_xfer(host_cmd_pkg::OP_WRITE, $urandom_range(127, 64), 8'($urandom), rsp);
        check("write byte flag out of range", 32'(rsp.flag), 1);
        host_xfer(host_cmd_pkg::OP_WRITE_LEN, 0, 8'h00, rsp);
        check("write length", 32'(rsp.data), 64);
        host_xfer(host_cmd_pkg::OP_WRITE_NEXT, 0, 8'h00, rsp);
        check("host_rsp.flag", 32'(rsp.flag), 0);
        push_tx_model(p);
        p.delete();
        repeat (3) begin
            host_xfer(host_cmd_pkg::OP_WRITE_NEXT, 0, 8'h00, rsp);
            check("host_rsp.flag", 32'(rsp.flag), 0);
            push_tx_model(p);
        end
        host_xfer(host_cmd_pkg::OP_WRITE_NEXT, 0, 8'h00, rsp);
        check("write next flag on full ring", 32'(rsp.flag), 1);
        wait_tx_drained();

        // good receive frames
        repeat (3) begin
            p = rand_payload($urandom_range(64, 1));
            push_rx_model(p);
            send_rx_frame(p, GOOD);
        end
        repeat (3) read_rx_frame();
        check_rx_empty();

        // bad frames are dropped
        send_rx_frame(rand_payload($urandom_range(64, 1)), BAD_FCS);
        send_rx_frame(rand_payload($urandom_range(64, 1)), RX_ERR);
        send_rx_frame(rand_payload($urandom_range(64, 1)), BAD_PRE);
        send_rx_frame(rand_payload($urandom_range(80, 65)), GOOD);
        p = rand_payload($urandom_range(64, 1));
        push_rx_model(p);
        send_rx_frame(p, GOOD);
        read_rx_frame();
        check_rx_empty();

        // fifth frame finds the ring full
        for (int k = 0; k < 5; k++) begin
            p = rand_payload($urandom_range(64, 1));
            if (k < eth_frame_pkg::RING_SLOTS) begin
                push_rx_model(p);
            end
            send_rx_frame(p, GOOD);
        end
        repeat (4) read_rx_frame();
        check_rx_empty();

        // both directions at once
        gap_max = 3;
        rx_done = 1'b0;
        fork
            begin
                repeat (6) begin
                    write_tx_frame(rand_payload($urandom_range(40, 1)));
                    drain_rx();
                end
                n = 0;
                while (!rx_done || rx_len_q.size() != 0) begin
                    drain_rx();
                    n++;
                    if (n > TIMEOUT) begin
                        fail_run("timeout reading receive frames");
                    end
                end
            end
            begin
                repeat (6) begin
                    wait_rx_room();
                    rx_p = rand_payload($urandom_range(64, 1));
                    push_rx_model(rx_p);
                    send_rx_frame(rx_p, GOOD);
                    repeat ($urandom_range(20, 0)) @(posedge clock);
                end
                rx_done = 1'b1;
            end
        join
        wait_tx_drained();
        check_rx_empty();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/eth_frame_pkg.sv
`default_nettype none

package eth_frame_pkg;

    localparam int RING_SLOTS = 4;
    localparam int SLOT_IDX_W = 2;
    localparam int MAX_FRAME_BYTES = 64;
    localparam int BYTE_ADDR_W = 6;  // offset inside one slot
    localparam int LEN_W = 7;

    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam int PREAMBLE_LEN = 7;
    localparam logic [7:0] SFD_BYTE = 8'hd5;
    localparam int FCS_BYTES = 4;
    localparam int IFG_CYCLES = 12;

    localparam logic [31:0] CRC_POLY = 32'hedb88320;  // 0x04c11db7 bit-reversed
    localparam logic [31:0] CRC_INIT = 32'hffffffff;
    localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

    // lsb-first CRC-32, one byte per call
    function automatic logic [31:0] crc32_byte(input logic [7:0] data, input logic [31:0] crc);
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? (c >> 1) ^ CRC_POLY : c >> 1;
        end
        return c;
    endfunction

    typedef struct packed {
        logic [7:0] data;
        logic       en;
    } gmii_tx_t;

    typedef struct packed {
        logic [7:0] data;
        logic       dv;
        logic       er;
    } gmii_rx_t;

    typedef struct packed {
        logic             we;
        logic [LEN_W-1:0] addr;
        logic [7:0]       data;
        logic             commit;  // close open slot
        logic             abort;   // drop open slot contents
    } ring_wr_t;

    typedef struct packed {
        logic [LEN_W-1:0] addr;
        logic             free;    // release head slot
    } ring_rd_t;

endpackage

`default_nettype wire

// File: verilog/eth_mac_top.sv
`timescale 1ns/100ps
`default_nettype none

module eth_mac_top (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    host_req,
    input  host_cmd_pkg::host_cmd_t host_cmd,
    output logic                    host_ack,
    output host_cmd_pkg::host_rsp_t host_rsp,
    output eth_frame_pkg::gmii_tx_t gmii_tx,
    input  eth_frame_pkg::gmii_rx_t gmii_rx
);

    eth_frame_pkg::ring_wr_t tx_wr;
    eth_frame_pkg::ring_rd_t tx_rd;
    eth_frame_pkg::ring_wr_t rx_wr;
    eth_frame_pkg::ring_rd_t rx_rd;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;
    logic [eth_frame_pkg::LEN_W-1:0] tx_head_len;
    logic [eth_frame_pkg::LEN_W-1:0] tx_open_len;
    logic [eth_frame_pkg::LEN_W-1:0] rx_head_len;
    logic tx_full;
    logic tx_empty;
    logic rx_full;
    logic rx_empty;

    pkt_ring tx_ring (
        .clock    (clock),
        .reset    (reset),
        .wr       (tx_wr),
        .rd       (tx_rd),
        .rd_byte  (tx_byte),
        .head_len (tx_head_len),
        .open_len (tx_open_len),
        .full     (tx_full),
        .empty    (tx_empty)
    );

    pkt_ring rx_ring (
        .clock    (clock),
        .reset    (reset),
        .wr       (rx_wr),
        .rd       (rx_rd),
        .rd_byte  (rx_byte),
        .head_len (rx_head_len),
        .open_len (),            // deframer tracks its own byte count
        .full     (rx_full),
        .empty    (rx_empty)
    );

    gmii_tx_framer tx_framer (
        .clock      (clock),
        .reset      (reset),
        .ring_empty (tx_empty),
        .head_len   (tx_head_len),
        .rd_byte    (tx_byte),
        .rd         (tx_rd),
        .gmii_tx    (gmii_tx)
    );

    gmii_rx_deframer rx_deframer (
        .clock     (clock),
        .reset     (reset),
        .gmii_rx   (gmii_rx),
        .ring_full (rx_full),
        .wr        (rx_wr)
    );

    host_cmd_decoder cmd_decoder (
        .clock       (clock),
        .reset       (reset),
        .host_req    (host_req),
        .host_cmd    (host_cmd),
        .tx_full     (tx_full),
        .tx_open_len (tx_open_len),
        .rx_empty    (rx_empty),
        .rx_head_len (rx_head_len),
        .rx_byte     (rx_byte),
        .host_ack    (host_ack),
        .host_rsp    (host_rsp),
        .tx_wr       (tx_wr),
        .rx_rd       (rx_rd)
    );

endmodule

`default_nettype wire

// File: verilog/gmii_rx_deframer.sv
`timescale 1ns/100ps
`default_nettype none

module gmii_rx_deframer (
    input  logic                    clock,
    input  logic                    reset,
    input  eth_frame_pkg::gmii_rx_t gmii_rx,
    input  logic                    ring_full,
    output eth_frame_pkg::ring_wr_t wr
);

    typedef enum logic [1:0] {
        st_idle,
        st_pre,
        st_data,
        st_drop
    } state_t;

    localparam int LEN_W = eth_frame_pkg::LEN_W;

    state_t state;
    logic [LEN_W-1:0] cnt;  // preamble bytes, then bytes after sfd
    logic [31:0] crc;
    logic [31:0] delay;     // last four bytes, the fcs never reaches the slot

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            cnt <= '0;
            wr <= '0;
        end else begin
            wr.we <= 1'b0;
            wr.commit <= 1'b0;
            wr.abort <= 1'b0;
            case (state)
                st_idle: begin
                    if (gmii_rx.dv) begin
                        cnt <= LEN_W'(1);
                        if (gmii_rx.data == eth_frame_pkg::PREAMBLE_BYTE && !gmii_rx.er) begin
                            state <= st_pre;
                        end else begin
                            state <= st_drop;
                        end
                    end
                end
                st_pre: begin
                    if (!gmii_rx.dv) begin
                        state <= st_idle;
                    end else if (gmii_rx.er) begin
                        state <= st_drop;
                    end else if (cnt < LEN_W'(eth_frame_pkg::PREAMBLE_LEN)) begin
                        cnt <= cnt + 1'b1;
                        if (gmii_rx.data != eth_frame_pkg::PREAMBLE_BYTE) begin
                            state <= st_drop;
                        end
                    end else if (gmii_rx.data == eth_frame_pkg::SFD_BYTE && !ring_full) begin
                        state <= st_data;
                        cnt <= '0;
                        crc <= eth_frame_pkg::CRC_INIT;
                    end else begin
                        state <= st_drop;
                    end
                end
                st_data: begin
                    if (!gmii_rx.dv) begin
                        state <= st_idle;
                        if (crc == eth_frame_pkg::CRC_RESIDUE &&
                            cnt >= LEN_W'(eth_frame_pkg::FCS_BYTES)) begin
                            wr.commit <= 1'b1;
                        end else begin
                            wr.abort <= 1'b1;
                        end
                    end else if (gmii_rx.er || cnt == LEN_W'(eth_frame_pkg::MAX_FRAME_BYTES +
                                                              eth_frame_pkg::FCS_BYTES)) begin
                        wr.abort <= 1'b1;  // error or oversize
                        state <= st_drop;
                    end else begin
                        crc <= eth_frame_pkg::crc32_byte(gmii_rx.data, crc);
                        delay <= {delay[23:0], gmii_rx.data};
                        cnt <= cnt + 1'b1;
                        if (cnt >= LEN_W'(eth_frame_pkg::FCS_BYTES)) begin
                            wr.we <= 1'b1;
                            wr.addr <= cnt - LEN_W'(eth_frame_pkg::FCS_BYTES);
                            wr.data <= delay[31:24];
                        end
                    end
                end
                st_drop: begin
                    if (!gmii_rx.dv) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/gmii_tx_framer.sv
`timescale 1ns/100ps
`default_nettype none

module gmii_tx_framer (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            ring_empty,
    input  logic [eth_frame_pkg::LEN_W-1:0] head_len,
    input  logic [7:0]                      rd_byte,
    output eth_frame_pkg::ring_rd_t         rd,
    output eth_frame_pkg::gmii_tx_t         gmii_tx
);

    typedef enum logic [2:0] {
        st_idle,
        st_pre,
        st_sfd,
        st_data,
        st_fcs,
        st_gap
    } state_t;

    state_t state;
    logic [3:0] cnt;
    logic [31:0] crc;

    // rd.addr runs one byte ahead of the byte on the wire
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            cnt <= '0;
            rd <= '0;
            gmii_tx <= '0;
        end else begin
            rd.free <= 1'b0;
            case (state)
                st_idle: begin
                    gmii_tx.en <= 1'b0;
                    if (!ring_empty) begin
                        state <= st_pre;
                        cnt <= '0;
                        rd.addr <= '0;
                        crc <= eth_frame_pkg::CRC_INIT;
                    end
                end
                st_pre: begin
                    gmii_tx <= '{data: eth_frame_pkg::PREAMBLE_BYTE, en: 1'b1};
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'(eth_frame_pkg::PREAMBLE_LEN - 1)) begin
                        state <= st_sfd;
                    end
                end
                st_sfd: begin
                    gmii_tx <= '{data: eth_frame_pkg::SFD_BYTE, en: 1'b1};
                    cnt <= '0;
                    rd.addr <= rd.addr + 1'b1;  // byte 0 is already on rd_byte
                    state <= (head_len == '0) ? st_fcs : st_data;
                end
                st_data: begin
                    gmii_tx <= '{data: rd_byte, en: 1'b1};
                    crc <= eth_frame_pkg::crc32_byte(rd_byte, crc);
                    rd.addr <= rd.addr + 1'b1;
                    if (rd.addr == head_len) begin
                        state <= st_fcs;
                    end
                end
                st_fcs: begin
                    gmii_tx <= '{data: ~crc[7:0], en: 1'b1};  // low byte first
                    crc <= crc >> 8;
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'(eth_frame_pkg::FCS_BYTES - 1)) begin
                        state <= st_gap;
                        cnt <= '0;
                        rd.free <= 1'b1;
                    end
                end
                st_gap: begin
                    gmii_tx.en <= 1'b0;
                    cnt <= cnt + 1'b1;
                    if (cnt == 4'(eth_frame_pkg::IFG_CYCLES - 1)) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/host_cmd_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module host_cmd_decoder (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            host_req,
    input  host_cmd_pkg::host_cmd_t         host_cmd,
    input  logic                            tx_full,
    input  logic [eth_frame_pkg::LEN_W-1:0] tx_open_len,
    input  logic                            rx_empty,
    input  logic [eth_frame_pkg::LEN_W-1:0] rx_head_len,
    input  logic [7:0]                      rx_byte,
    output logic                            host_ack,
    output host_cmd_pkg::host_rsp_t         host_rsp,
    output eth_frame_pkg::ring_wr_t         tx_wr,
    output eth_frame_pkg::ring_rd_t         rx_rd
);

    typedef enum logic [2:0] {
        st_idle,
        st_exec,
        st_resp,
        st_hold,
        st_done
    } state_t;

    state_t state;
    logic rx_free;

    // addr is stable for the whole request, so rx_byte is ready by st_exec
    assign rx_rd = '{addr: host_cmd.addr, free: rx_free};

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            host_ack <= 1'b0;
            tx_wr <= '0;
            rx_free <= 1'b0;
        end else begin
            tx_wr.we <= 1'b0;
            tx_wr.commit <= 1'b0;
            rx_free <= 1'b0;
            case (state)
                st_idle: begin
                    if (host_req) begin
                        state <= st_exec;
                    end
                end
                st_exec: begin
                    state <= st_resp;
                    host_rsp <= '0;
                    case (host_cmd.op)
                        host_cmd_pkg::OP_READ: begin
                            if (host_cmd.addr < rx_head_len) begin
                                host_rsp.data <= 16'(rx_byte);
                            end
                        end
                        host_cmd_pkg::OP_READ_LEN: host_rsp.data <= 16'(rx_head_len);
                        host_cmd_pkg::OP_READ_NEXT: begin
                            host_rsp.flag <= rx_empty;
                            rx_free <= !rx_empty;
                        end
                        host_cmd_pkg::OP_WRITE: begin
                            if (host_cmd.addr >=
                                eth_frame_pkg::LEN_W'(eth_frame_pkg::MAX_FRAME_BYTES)) begin
                                host_rsp.flag <= 1'b1;
                            end else begin
                                tx_wr.we <= 1'b1;
                                tx_wr.addr <= host_cmd.addr;
                                tx_wr.data <= host_cmd.value;
                            end
                        end
                        host_cmd_pkg::OP_WRITE_LEN: host_rsp.data <= 16'(tx_open_len);
                        host_cmd_pkg::OP_WRITE_NEXT: begin
                            host_rsp.flag <= tx_full;
                            tx_wr.commit <= !tx_full;
                        end
                        default: ;
                    endcase
                end
                st_resp: begin
                    host_ack <= 1'b1;  // second edge after req was seen
                    state <= st_hold;
                end
                st_hold: begin
                    if (!host_req) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    host_ack <= 1'b0;
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/host_cmd_pkg.sv
`default_nettype none

package host_cmd_pkg;

    typedef enum logic [2:0] {
        OP_READ,
        OP_READ_LEN,
        OP_READ_NEXT,
        OP_WRITE,
        OP_WRITE_LEN,
        OP_WRITE_NEXT
    } host_op_t;

    typedef struct packed {
        host_op_t                         op;
        logic [eth_frame_pkg::LEN_W-1:0]  addr;
        logic [7:0]                       value;
    } host_cmd_t;

    typedef struct packed {
        logic [15:0] data;
        logic        flag;
    } host_rsp_t;

endpackage

`default_nettype wire

// File: verilog/pkt_ring.sv
`timescale 1ns/100ps
`default_nettype none

module pkt_ring (
    input  logic                            clock,
    input  logic                            reset,
    input  eth_frame_pkg::ring_wr_t         wr,
    input  eth_frame_pkg::ring_rd_t         rd,
    output logic [7:0]                      rd_byte,
    output logic [eth_frame_pkg::LEN_W-1:0] head_len,
    output logic [eth_frame_pkg::LEN_W-1:0] open_len,
    output logic                            full,
    output logic                            empty
);

    logic [7:0] mem [eth_frame_pkg::RING_SLOTS * eth_frame_pkg::MAX_FRAME_BYTES];
    logic [eth_frame_pkg::LEN_W-1:0] len [eth_frame_pkg::RING_SLOTS];
    logic [eth_frame_pkg::SLOT_IDX_W:0] head;  // extra msb tells full from empty
    logic [eth_frame_pkg::SLOT_IDX_W:0] tail;
    logic [eth_frame_pkg::SLOT_IDX_W-1:0] head_idx;
    logic [eth_frame_pkg::SLOT_IDX_W-1:0] tail_idx;
    logic wr_ok;

    assign head_idx = head[eth_frame_pkg::SLOT_IDX_W-1:0];
    assign tail_idx = tail[eth_frame_pkg::SLOT_IDX_W-1:0];
    assign empty = head == tail;
    assign full = head_idx == tail_idx &&
                  head[eth_frame_pkg::SLOT_IDX_W] != tail[eth_frame_pkg::SLOT_IDX_W];
    assign head_len = empty ? '0 : len[head_idx];
    assign open_len = full ? '0 : len[tail_idx];
    assign wr_ok = wr.we && !full;  // open slot aliases head when full

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[{tail_idx, wr.addr[eth_frame_pkg::BYTE_ADDR_W-1:0]}] <= wr.data;
        end
        rd_byte <= mem[{head_idx, rd.addr[eth_frame_pkg::BYTE_ADDR_W-1:0]}];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < eth_frame_pkg::RING_SLOTS; i++) begin
                len[i] <= '0;
            end
        end else begin
            if (wr_ok && wr.addr >= len[tail_idx]) begin
                len[tail_idx] <= wr.addr + 1'b1;
            end
            if (wr.abort && !full) begin
                len[tail_idx] <= '0;
            end
            if (wr.commit && !full) begin
                tail <= tail + 1'b1;
            end
            if (rd.free && !empty) begin
                len[head_idx] <= '0;  // slot comes back as an empty open slot
                head <= head + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire
